// ==== tb.f ====
common/fabric_pkg.sv
logic/nic_reset_seq.sv
target_crossbar/tgt_decode.sv
target_crossbar/func_regs.sv
target_crossbar/tgt_collect.sv
logic/target_fabric_top.sv
test/tb_target_fabric.sv

// ==== Bender.yml ====
package:
  name: target_fabric

sources:
  - common/fabric_pkg.sv
  - logic/nic_reset_seq.sv
  - target_crossbar/tgt_decode.sv
  - target_crossbar/func_regs.sv
  - target_crossbar/tgt_collect.sv
  - logic/target_fabric_top.sv
  - target: test
    files:
      - test/tb_target_fabric.sv

// ==== test/tb_target_fabric.sv ====
`timescale 1ns/1ps

module tb_target_fabric;

	import fabric_pkg::*;

	localparam int NUM_SLOTS = 3;
	localparam int WAIT_MAX = 200;

	logic              nic_clk;
	logic              ext_rst;
	logic              clk_lock_i;
	logic [ADDR_W-1:0] paddr_i;
	logic              psel_i;
	logic              penable_i;
	logic              pwrite_i;
	logic [DATA_W-1:0] pwdata_i;
	logic [STRB_W-1:0] pstrb_i;
	logic [DATA_W-1:0] prdata_o;
	logic              pready_o;
	logic              pslverr_o;
	logic              intr_request_o;
	logic              nic_rst_o;

	// Results of the last bus access
	logic [DATA_W-1:0] rd_q;
	logic              err_q;
	logic              irq_rdy_q;
	int                cyc_q;

	// Register model, words 1 to 3 of each slot
	logic [DATA_W-1:0] model [NUM_SLOTS][4];
	logic              last_irq;
	logic [31:0]       lfsr_q = 32'h2d7a_095d;
	int                value_errs = 0;
	int                other_errs = 0;

	target_fabric_top #(.NUM_SLOTS(NUM_SLOTS)) dut (.*);

	initial begin
		nic_clk = 1'b0;
		forever #2 nic_clk = ~nic_clk;
	end

	// Host must never see a response while the fabric is in reset
	assert property (@(posedge nic_clk) disable iff (ext_rst) nic_rst_o |-> !pready_o)
		else begin
			other_errs++;
			$display("pready_o was high while nic_rst_o was high");
		end

	// Error only together with the response
	assert property (@(posedge nic_clk) disable iff (ext_rst) pslverr_o |-> pready_o)
		else begin
			other_errs++;
			$display("pslverr_o was high outside a pready_o cycle");
		end

	task automatic abort_run(input string what);
		other_errs++;
		$display("Timeout: %s", what);
		$display("Summary: %0d value mismatches, %0d other failures", value_errs, other_errs);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else begin
				value_errs++;
				$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			end
	endtask

	// One output bit per LFSR step
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
		end
		return r;
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input int slot, input logic [1:0] word);
		return {8'h00, 4'(slot), word, 2'b00};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
			input logic [3:0] strb);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				r[b*8 +: 8] = nw[b*8 +: 8];
			end
		end
		return r;
	endfunction

	// Setup cycle, then access phase held until pready_o
	task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		int n;
		@(posedge nic_clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= wr;
		paddr_i <= addr;
		pwdata_i <= data;
		pstrb_i <= strb;
		@(posedge nic_clk);
		penable_i <= 1'b1;
		n = 0;
		do begin
			@(negedge nic_clk);
			n++;
		end while (!pready_o && n < WAIT_MAX);
		if (!pready_o) abort_run("pready_o never rose during an APB access");
		cyc_q = n;
		rd_q = prdata_o;
		err_q = pslverr_o;
		irq_rdy_q = intr_request_o;
		@(posedge nic_clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
	endtask

	// Counts negedges until nic_rst_o reaches the level
	task automatic wait_nic_rst(input logic level, output int n);
		n = 0;
		do begin
			@(negedge nic_clk);
			n++;
			if (n > WAIT_MAX) abort_run("nic_rst_o never reached the expected level");
		end while (nic_rst_o !== level);
	endtask

	// Interrupt line follows one cycle after the write
	task automatic write_irq_reg(input int s, input logic [1:0] w, input logic [31:0] d,
			input logic exp);
		bus_access(1'b1, reg_addr(s, w), d, 4'hF);
		check_equal("intr_request_o at pready", 32'(irq_rdy_q), 32'(last_irq));
		@(negedge nic_clk);
		check_equal("intr_request_o", 32'(intr_request_o), 32'(exp));
		last_irq = exp;
	endtask

	initial begin
		int n;
		int s;
		logic [1:0] w;
		logic [31:0] d;
		logic [3:0] b;
		ext_rst = 1'b1;
		clk_lock_i = 1'b1;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		pstrb_i = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			for (int j = 0; j < 4; j++) begin
				model[i][j] = '0;
			end
		end
		repeat (4) @(posedge nic_clk);
		ext_rst <= 1'b0;

		// Internal reset release, then identity words
		wait_nic_rst(1'b0, n);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			bus_access(1'b0, reg_addr(i, REG_ID), '0, '0);
			check_equal("prdata_o", rd_q, {ID_MAGIC, 8'(i)});
		end

		// Random strobed writes, read back against the model
		// Sweep walks every writable word of every slot
		for (int i = 0; i < 24; i++) begin
			s = i % NUM_SLOTS;
			w = 2'(1 + (i / NUM_SLOTS) % 3);
			d = rand_bits(32);
			b = 4'(rand_bits(4));
			bus_access(1'b1, reg_addr(s, w), d, b);
			check_equal("pslverr_o", 32'(err_q), 32'h0);
			check_equal("pready_o access cycles", 32'(cyc_q), 32'd2);
			model[s][w] = merge_bytes(model[s][w], d, b);
			bus_access(1'b0, reg_addr(s, w), '0, '0);
			check_equal("prdata_o", rd_q, model[s][w]);
		end

		// Unmapped slots
		bus_access(1'b1, reg_addr(3, REG_SCRATCH), 32'hFFFF_FFFF, 4'hF);
		check_equal("pslverr_o", 32'(err_q), 32'h1);
		bus_access(1'b0, reg_addr(15, REG_ID), '0, '0);
		check_equal("pslverr_o", 32'(err_q), 32'h1);
		check_equal("prdata_o", rd_q, 32'h0);

		// Interrupt combining, starting from all clear
		for (int i = 0; i < NUM_SLOTS; i++) begin
			bus_access(1'b1, reg_addr(i, REG_IRQ_PEND), '0, 4'hF);
			bus_access(1'b1, reg_addr(i, REG_IRQ_EN), '0, 4'hF);
		end
		@(negedge nic_clk);
		check_equal("intr_request_o", 32'(intr_request_o), 32'h0);
		last_irq = 1'b0;
		write_irq_reg(1, REG_IRQ_EN, 32'h0000_0010, 1'b0);
		write_irq_reg(1, REG_IRQ_PEND, 32'h0000_0030, 1'b1);
		write_irq_reg(1, REG_IRQ_PEND, 32'h0000_0020, 1'b0);
		write_irq_reg(2, REG_IRQ_PEND, 32'hFFFF_FFFF, 1'b0);
		write_irq_reg(2, REG_IRQ_EN, 32'h8000_0000, 1'b1);
		bus_access(1'b1, reg_addr(0, REG_SCRATCH), 32'hA5A5_5A5A, 4'hF);

		// Reset request by key, 64 cycles of internal reset
		bus_access(1'b1, reg_addr(2, REG_ID), RST_KEY, 4'hF);
		wait_nic_rst(1'b1, n);
		wait_nic_rst(1'b0, n);
		check_equal("nic_rst_o high cycles", 32'(n), 32'd64);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			bus_access(1'b0, reg_addr(i, REG_SCRATCH), '0, '0);
			check_equal("prdata_o", rd_q, 32'h0);
		end
		// Collector has sampled the cleared slots by now
		@(negedge nic_clk);
		check_equal("intr_request_o", 32'(intr_request_o), 32'h0);

		// Lost lock stalls an access until the count ends
		@(posedge nic_clk);
		clk_lock_i <= 1'b0;
		wait_nic_rst(1'b1, n);
		fork
			bus_access(1'b0, reg_addr(1, REG_ID), '0, '0);
			begin
				repeat (10) @(posedge nic_clk);
				clk_lock_i <= 1'b1;
			end
		join
		assert (cyc_q > 64)
			else begin
				other_errs++;
				$display("access completed before the clock lock reset had ended");
			end
		check_equal("prdata_o", rd_q, {ID_MAGIC, 8'h01});

		$display("Summary: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/target_fabric_top.sv ====
`timescale 1ns/1ps

module target_fabric_top #(
	parameter int NUM_SLOTS = 3
) (
	input  logic                          nic_clk,
	input  logic                          ext_rst,
	input  logic                          clk_lock_i,
	input  logic [fabric_pkg::ADDR_W-1:0] paddr_i,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [fabric_pkg::DATA_W-1:0] pwdata_i,
	input  logic [fabric_pkg::STRB_W-1:0] pstrb_i,
	output logic [fabric_pkg::DATA_W-1:0] prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	output logic                          intr_request_o,
	output logic                          nic_rst_o
);

	import fabric_pkg::*;

	logic                        nic_rst;
	logic                        rst_req;

	// Shared request lines toward the slots
	logic [NUM_SLOTS-1:0]        acc;
	logic                        we;
	logic [WORD_W-1:0]           word;
	logic [DATA_W-1:0]           wdata;
	logic [STRB_W-1:0]           strb;

	// Per-slot return lines, packed by slot index
	logic [NUM_SLOTS*DATA_W-1:0] slot_rdata;
	logic [NUM_SLOTS-1:0]        slot_irq;
	logic [NUM_SLOTS-1:0]        slot_rst_req;

	nic_reset_seq u_reset_seq (
		.nic_clk    (nic_clk),
		.ext_rst    (ext_rst),
		.clk_lock_i (clk_lock_i),
		.rst_req_i  (rst_req),
		.nic_rst_o  (nic_rst)
	);

	assign nic_rst_o = nic_rst;

	tgt_decode #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_decode (
		.nic_clk   (nic_clk),
		.nic_rst_i (nic_rst),
		.paddr_i   (paddr_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.pwdata_i  (pwdata_i),
		.pstrb_i   (pstrb_i),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.acc_o     (acc),
		.we_o      (we),
		.word_o    (word),
		.wdata_o   (wdata),
		.strb_o    (strb)
	);

	// One register bank per device-function slot
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		func_regs #(
			.SLOT_IDX (i)
		) u_regs (
			.nic_clk   (nic_clk),
			.nic_rst_i (nic_rst),
			.acc_i     (acc[i]),
			.we_i      (we),
			.word_i    (word),
			.wdata_i   (wdata),
			.strb_i    (strb),
			.rdata_o   (slot_rdata[i*DATA_W +: DATA_W]),
			.irq_o     (slot_irq[i]),
			.rst_req_o (slot_rst_req[i])
		);
	end

	tgt_collect #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_collect (
		.nic_clk        (nic_clk),
		.nic_rst_i      (nic_rst),
		.rdata_i        (slot_rdata),
		.irq_i          (slot_irq),
		.rst_req_i      (slot_rst_req),
		.prdata_o       (prdata_o),
		.intr_request_o (intr_request_o),
		.rst_req_o      (rst_req)
	);

endmodule

// ==== target_crossbar/tgt_collect.sv ====
`timescale 1ns/1ps

module tgt_collect #(
	parameter int NUM_SLOTS = 3
) (
	input  logic                                    nic_clk,
	input  logic                                    nic_rst_i,
	input  logic [NUM_SLOTS*fabric_pkg::DATA_W-1:0] rdata_i,
	input  logic [NUM_SLOTS-1:0]                    irq_i,
	input  logic [NUM_SLOTS-1:0]                    rst_req_i,
	output logic [fabric_pkg::DATA_W-1:0]           prdata_o,
	output logic                                    intr_request_o,
	output logic                                    rst_req_o
);

	import fabric_pkg::*;

	// Only the answering slot drives nonzero data
	always_comb begin
		prdata_o = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			prdata_o = prdata_o | rdata_i[i*DATA_W +: DATA_W];
		end
	end

	// Single interrupt line, one flop behind the slots
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			intr_request_o <= 1'b0;
		end else begin
			intr_request_o <= |irq_i;
		end
	end

	// Any slot may restart the whole fabric
	assign rst_req_o = |rst_req_i;

endmodule

// ==== target_crossbar/func_regs.sv ====
`timescale 1ns/1ps

module func_regs #(
	parameter int SLOT_IDX = 0
) (
	input  logic                          nic_clk,
	input  logic                          nic_rst_i,
	input  logic                          acc_i,
	input  logic                          we_i,
	input  logic [fabric_pkg::WORD_W-1:0] word_i,
	input  logic [fabric_pkg::DATA_W-1:0] wdata_i,
	input  logic [fabric_pkg::STRB_W-1:0] strb_i,
	output logic [fabric_pkg::DATA_W-1:0] rdata_o,
	output logic                          irq_o,
	output logic                          rst_req_o
);

	import fabric_pkg::*;

	logic [DATA_W-1:0] irq_en_q;
	logic [DATA_W-1:0] irq_pend_q;
	logic [DATA_W-1:0] scratch_q;
	logic [DATA_W-1:0] id_word;
	logic [DATA_W-1:0] rd_mux;
	logic              wr_acc;
	logic              rd_acc;

	// Read-only identity word
	assign id_word = {ID_MAGIC, 8'(SLOT_IDX)};

	assign wr_acc = acc_i && we_i;
	assign rd_acc = acc_i && !we_i;

	always_comb begin
		unique case (word_i)
			REG_ID:       rd_mux = id_word;
			REG_IRQ_EN:   rd_mux = irq_en_q;
			REG_IRQ_PEND: rd_mux = irq_pend_q;
			default:      rd_mux = scratch_q;
		endcase
	end

	// Byte-lane writes to the writable words
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			irq_en_q   <= '0;
			irq_pend_q <= '0;
			scratch_q  <= '0;
		end else if (wr_acc) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (strb_i[b]) begin
					unique case (word_i)
						REG_IRQ_EN:   irq_en_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
						REG_IRQ_PEND: irq_pend_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
						REG_SCRATCH:  scratch_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
						default:      ;
					endcase
				end
			end
		end
	end

	// Read data held for the RESP cycle only
	// Zero otherwise so the collector can OR all slots
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= rd_acc ? rd_mux : '0;
		end
	end

	// Reset key must arrive as a full word on REG_ID
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			rst_req_o <= 1'b0;
		end else begin
			rst_req_o <= wr_acc && word_i == REG_ID && &strb_i && wdata_i == RST_KEY;
		end
	end

	// Pending and enabled
	assign irq_o = |(irq_en_q & irq_pend_q);

endmodule

// ==== target_crossbar/tgt_decode.sv ====
`timescale 1ns/1ps

module tgt_decode #(
	parameter int NUM_SLOTS = 3
) (
	input  logic                          nic_clk,
	input  logic                          nic_rst_i,
	input  logic [fabric_pkg::ADDR_W-1:0] paddr_i,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [fabric_pkg::DATA_W-1:0] pwdata_i,
	input  logic [fabric_pkg::STRB_W-1:0] pstrb_i,
	output logic                          pready_o,
	output logic                          pslverr_o,
	output logic [NUM_SLOTS-1:0]          acc_o,
	output logic                          we_o,
	output logic [fabric_pkg::WORD_W-1:0] word_o,
	output logic [fabric_pkg::DATA_W-1:0] wdata_o,
	output logic [fabric_pkg::STRB_W-1:0] strb_o
);

	import fabric_pkg::*;

	dec_state_e        state_q;
	logic              err_q;
	logic [SLOT_W-1:0] slot;
	logic              mapped;
	logic              start;

	// Slot field sits right above the word index
	assign slot   = paddr_i[2+WORD_W +: SLOT_W];
	assign mapped = int'(slot) < NUM_SLOTS;

	// First access cycle of a transfer
	assign start = (state_q == DEC_IDLE) && psel_i && penable_i;

	// One-hot strobe toward the addressed slot
	// Unmapped slot numbers select nothing
	always_comb begin
		acc_o = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (start && slot == SLOT_W'(i)) begin
				acc_o[i] = 1'b1;
			end
		end
	end

	// Shared write side, valid while acc_o is up
	assign we_o    = pwrite_i;
	assign word_o  = paddr_i[2 +: WORD_W];
	assign wdata_o = pwdata_i;
	assign strb_o  = pstrb_i;

	// Two-cycle access phase
	// IDLE issues the strobe, RESP answers with pready
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			state_q <= DEC_IDLE;
			err_q   <= 1'b0;
		end else begin
			unique case (state_q)
				DEC_IDLE: begin
					if (start) begin
						state_q <= DEC_RESP;
						err_q   <= !mapped;
					end
				end
				DEC_RESP: begin
					state_q <= DEC_IDLE;
					err_q   <= 1'b0;
				end
				default: begin
					state_q <= DEC_IDLE;
					err_q   <= 1'b0;
				end
			endcase
		end
	end

	// Fixed single wait state
	assign pready_o = (state_q == DEC_RESP);

	// Error flag only lives during RESP
	assign pslverr_o = err_q;

endmodule

// ==== logic/nic_reset_seq.sv ====
`timescale 1ns/1ps

module nic_reset_seq (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_lock_i,
	input  logic rst_req_i,
	output logic nic_rst_o
);

	import fabric_pkg::*;

	logic [RST_CNT_W-1:0] rst_cnt;
	logic                 rst_done;

	// Top bit marks the end of the hold time
	assign rst_done = rst_cnt[RST_CNT_W-1];

	// Restart the count on any reset cause
	// Lost lock keeps it parked at zero until lock returns
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rst_cnt <= '0;
		end else if (rst_req_i || !clk_lock_i) begin
			rst_cnt <= '0;
		end else if (!rst_done) begin
			rst_cnt <= rst_cnt + 1'b1;
		end
	end

	// Internal reset held until count completes
	assign nic_rst_o = !rst_done;

endmodule

// ==== common/fabric_pkg.sv ====
package fabric_pkg;

	// APB data path widths
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int ADDR_W = 16;

	// Address split
	// Bits 1:0 byte offset, then word index, then slot number
	localparam int WORD_W = 2;
	localparam int SLOT_W = 4;

	// Word indices inside one slot
	localparam logic [WORD_W-1:0] REG_ID = 2'd0;
	localparam logic [WORD_W-1:0] REG_IRQ_EN = 2'd1;
	localparam logic [WORD_W-1:0] REG_IRQ_PEND = 2'd2;
	localparam logic [WORD_W-1:0] REG_SCRATCH = 2'd3;

	// Upper part of the ID word
	// Low byte is filled with the slot number
	localparam logic [23:0] ID_MAGIC = 24'hE10_00F;

	// Full-word write of this key to REG_ID asks for a fabric reset
	localparam logic [DATA_W-1:0] RST_KEY = 32'hC0DE_5E7F;

	// Reset hold counter
	// Top bit sets 64 cycles after the last cause
	localparam int RST_CNT_W = 7;

	// Decoder FSM
	typedef enum logic [0:0] {
		DEC_IDLE = 1'b0,
		DEC_RESP = 1'b1
	} dec_state_e;

endpackage
